// ==== rtl/video_consts.svh ====
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ======================================
// Frame timing
// ======================================
`define H_ACTIVE    16
`define H_TOTAL     24
`define HS_START    18
`define HS_END      22
`define V_ACTIVE    8
`define V_TOTAL     12
`define VS_START    9
`define VS_END      11
// Raster count to video_out latency
`define PIPE_DELAY  2

// Tiles are 4x4, map is 8x2 tiles
`define TILE_SHIFT  2
`define MAP_COLS    8
`define MAP_ROWS    2

// Field widths
`define H_BITS      5
`define V_BITS      4
`define ROW_BITS    3
`define ADDR_BITS   4
`define INDEX_BITS  4
`define SCROLL_BITS 5
`define RGB_BITS    24

`endif

// ==== rtl/video_pkg.sv ====
`include "video_consts.svh"

package video_pkg;

    // Host write targets
    typedef enum logic [1:0] {
        HOST_TILE    = 2'd0,
        HOST_PALETTE = 2'd1,
        HOST_SCROLL  = 2'd2,
        HOST_BGCOLOR = 2'd3
    } host_target_e;

    typedef struct packed {
        logic                   wren;
        host_target_e           target;
        logic [`ADDR_BITS-1:0]  addr;
        logic [`RGB_BITS-1:0]   data;
    } host_write_t;

    // One-cycle pulse asking for a row to be built
    typedef struct packed {
        logic                   strobe;
        logic [`ROW_BITS-1:0]   row;
    } row_request_t;

    typedef struct packed {
        logic                   wren;
        logic [`ADDR_BITS-1:0]  addr;
        logic [`INDEX_BITS-1:0] index;
    } pixel_write_t;

    typedef struct packed {
        logic                   de;
        logic                   hs;
        logic                   vs;
        logic [`RGB_BITS-1:0]   rgb;
    } video_out_t;

    typedef enum logic {
        RENDER_IDLE,
        RENDER_ROW
    } render_state_e;

endpackage : video_pkg

// ==== rtl/row_renderer.sv ====
`include "video_consts.svh"

module row_renderer (
    input  logic                    clk,
    input  logic                    reset,
    input  video_pkg::host_write_t  host,
    input  video_pkg::row_request_t request,
    output video_pkg::pixel_write_t pixel
);

    import video_pkg::*;

    // Palette index per tile
    logic [`INDEX_BITS-1:0]  tile_map [`MAP_COLS*`MAP_ROWS];
    logic [`SCROLL_BITS-1:0] scroll;

    render_state_e           state;
    logic [`ADDR_BITS-1:0]   col;
    logic [`ROW_BITS-1:0]    row;

    logic [`SCROLL_BITS-1:0] map_x;
    logic [`ADDR_BITS-1:0]   tile_addr;

    // ======================================
    // Host registers
    // ======================================
    always_ff @(posedge clk) begin
        if (reset) begin
            scroll <= '0;
            for (int i = 0; i < `MAP_COLS*`MAP_ROWS; i++) begin
                tile_map[i] <= '0;
            end
        end else if (host.wren) begin
            if (host.target == HOST_TILE) begin
                tile_map[host.addr] <= host.data[`INDEX_BITS-1:0];
            end
            if (host.target == HOST_SCROLL) begin
                scroll <= host.data[`SCROLL_BITS-1:0];
            end
        end
    end

    // ======================================
    // Render FSM
    // ======================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RENDER_IDLE;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                RENDER_IDLE: begin
                    if (request.strobe) begin
                        state <= RENDER_ROW;
                        col   <= '0;
                        row   <= request.row;
                    end
                end
                RENDER_ROW: begin
                    col <= col + 1'b1;
                    // Last pixel of the row
                    if (col == `H_ACTIVE - 1) begin
                        state <= RENDER_IDLE;
                    end
                end
                default: begin
                    state <= RENDER_IDLE;
                end
            endcase
        end
    end

    // Scrolled x wraps at 32 through the 5-bit add
    assign map_x = {1'b0, col} + scroll;

    // Map row times MAP_COLS plus map column
    assign tile_addr = {row[`ROW_BITS-1:`TILE_SHIFT], map_x[`SCROLL_BITS-1:`TILE_SHIFT]};

    assign pixel.wren  = (state == RENDER_ROW);
    assign pixel.addr  = col;
    assign pixel.index = tile_map[tile_addr];

endmodule : row_renderer

// ==== rtl/row_buffer.sv ====
`include "video_consts.svh"

module row_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    swap,
    input  video_pkg::pixel_write_t pixel,
    input  logic [`ADDR_BITS-1:0]   rd_addr,
    output logic [`INDEX_BITS-1:0]  rd_index
);

    // Front bank is scanned out, back bank is rendered into
    logic [`INDEX_BITS-1:0] bank [2][`H_ACTIVE];
    logic                   front;

    always_ff @(posedge clk) begin
        if (reset) begin
            front    <= 1'b0;
            rd_index <= '0;
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < `H_ACTIVE; a++) begin
                    bank[b][a] <= '0;
                end
            end
        end else begin
            if (swap) begin
                front <= ~front;
            end
            if (pixel.wren) begin
                bank[~front][pixel.addr] <= pixel.index;
            end
            // Read sees the bank selected before this edge's swap
            rd_index <= bank[front][rd_addr];
        end
    end

endmodule : row_buffer

// ==== rtl/scanout.sv ====
`include "video_consts.svh"

module scanout (
    input  logic                    clk,
    input  logic                    reset,
    input  video_pkg::host_write_t  host,
    output video_pkg::row_request_t request,
    output logic                    swap,
    output logic [`ADDR_BITS-1:0]   rd_addr,
    input  logic [`INDEX_BITS-1:0]  rd_index,
    output video_pkg::video_out_t   video
);

    import video_pkg::*;

    logic [`H_BITS-1:0]   h_count;
    logic [`V_BITS-1:0]   v_count;
    logic [`V_BITS-1:0]   row_ahead;

    logic                 de_raw;
    logic                 hs_raw;
    logic                 vs_raw;
    logic                 de_d1;
    logic                 hs_d1;
    logic                 vs_d1;

    logic [`RGB_BITS-1:0] palette [1 << `INDEX_BITS];
    logic [`RGB_BITS-1:0] bg_color;
    logic [`RGB_BITS-1:0] color;

    // ======================================
    // Raster counters
    // ======================================
    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == `H_TOTAL - 1) begin
            h_count <= '0;
            if (v_count == `V_TOTAL - 1) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Row two lines ahead, wrapping into the next frame
    always_comb begin
        if (v_count >= `V_TOTAL - 2) begin
            row_ahead = v_count - `V_BITS'(`V_TOTAL - 2);
        end else begin
            row_ahead = v_count + `V_BITS'(2);
        end
    end

    // Swap at end of active pixels; request only visible rows
    assign swap           = (h_count == `H_ACTIVE);
    assign request.strobe = swap && (row_ahead < `V_ACTIVE);
    assign request.row    = row_ahead[`ROW_BITS-1:0];
    assign rd_addr        = h_count[`ADDR_BITS-1:0];

    // ======================================
    // Timing flags
    // ======================================
    assign de_raw = (h_count < `H_ACTIVE) && (v_count < `V_ACTIVE);
    assign hs_raw = (h_count >= `HS_START) && (h_count < `HS_END);
    assign vs_raw = (v_count >= `VS_START) && (v_count < `VS_END);

    // Stage one lines up with the buffer read
    always_ff @(posedge clk) begin
        if (reset) begin
            de_d1 <= 1'b0;
            hs_d1 <= 1'b0;
            vs_d1 <= 1'b0;
        end else begin
            de_d1 <= de_raw;
            hs_d1 <= hs_raw;
            vs_d1 <= vs_raw;
        end
    end

    // ======================================
    // Palette and output stage
    // ======================================
    always_ff @(posedge clk) begin
        if (reset) begin
            bg_color <= '0;
            for (int i = 0; i < (1 << `INDEX_BITS); i++) begin
                palette[i] <= '0;
            end
        end else if (host.wren) begin
            if (host.target == HOST_PALETTE) begin
                palette[host.addr] <= host.data;
            end
            if (host.target == HOST_BGCOLOR) begin
                bg_color <= host.data;
            end
        end
    end

    // Index 0 shows the background colour
    assign color = (rd_index == '0) ? bg_color : palette[rd_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            video <= '0;
        end else begin
            video.de  <= de_d1;
            video.hs  <= hs_d1;
            video.vs  <= vs_d1;
            video.rgb <= de_d1 ? color : '0;
        end
    end

endmodule : scanout

// ==== rtl/video_core.sv ====
`include "video_consts.svh"

module video_core (
    input  logic                   clk,
    input  logic                   reset,
    input  video_pkg::host_write_t host,
    output video_pkg::video_out_t  video
);

    import video_pkg::*;

    // ======================================
    // Interconnect
    // ======================================
    row_request_t           request;
    pixel_write_t           pixel;
    logic                   swap;
    logic [`ADDR_BITS-1:0]  rd_addr;
    logic [`INDEX_BITS-1:0] rd_index;

    // ======================================
    // Submodules
    // ======================================
    row_renderer u_row_renderer (
        .clk     (clk),
        .reset   (reset),
        .host    (host),
        .request (request),
        .pixel   (pixel)
    );

    row_buffer u_row_buffer (
        .clk      (clk),
        .reset    (reset),
        .swap     (swap),
        .pixel    (pixel),
        .rd_addr  (rd_addr),
        .rd_index (rd_index)
    );

    scanout u_scanout (
        .clk      (clk),
        .reset    (reset),
        .host     (host),
        .request  (request),
        .swap     (swap),
        .rd_addr  (rd_addr),
        .rd_index (rd_index),
        .video    (video)
    );

endmodule : video_core

// ==== dv/video_core_sva.sv ====
`include "video_consts.svh"

module video_core_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    swap,
    input video_pkg::row_request_t request,
    input video_pkg::video_out_t   video
);

    // Count of failed assertions
    int failures = 0;

    // ======================================
    // Sync and strobe properties
    // ======================================
    property hs_width;
        @(posedge clk) disable iff (reset)
        $rose(video.hs) |-> video.hs [*(`HS_END - `HS_START)] ##1 !video.hs;
    endproperty

    // One swap per line, exactly H_TOTAL clocks apart
    property swap_per_line;
        @(posedge clk) disable iff (reset)
        swap |=> !swap [*(`H_TOTAL - 1)] ##1 swap;
    endproperty

    // Requests walk through the visible rows, one per line swap
    property request_with_swap;
        @(posedge clk) disable iff (reset)
        (request.strobe && request.row != `V_ACTIVE - 1) |-> ##`H_TOTAL
            (swap && request.strobe && request.row == $past(request.row, `H_TOTAL) + 1'b1);
    endproperty

    property de_outside_sync;
        @(posedge clk) disable iff (reset)
        !(video.de && (video.hs || video.vs));
    endproperty

    assert property (hs_width) else begin
        failures++;
        $error("HSYNC pulse width is wrong");
    end
    assert property (swap_per_line) else begin
        failures++;
        $error("Swap is not a single pulse per line");
    end
    assert property (request_with_swap) else begin
        failures++;
        $error("Row requests out of step with the swaps");
    end
    assert property (de_outside_sync) else begin
        failures++;
        $error("DE high during sync");
    end

endmodule : video_core_sva

bind scanout video_core_sva i_video_core_sva (
    .clk     (clk),
    .reset   (reset),
    .swap    (swap),
    .request (request),
    .video   (video)
);

// ==== dv/video_core_tb.sv ====
`include "video_consts.svh"

module video_core_tb;

    import video_pkg::*;

    logic        clk;
    logic        reset;
    host_write_t host;
    video_out_t  video;

    // Copies of what the host has programmed
    logic [`INDEX_BITS-1:0]  model_tiles [`MAP_COLS*`MAP_ROWS];
    logic [`RGB_BITS-1:0]    model_palette [1 << `INDEX_BITS];
    logic [`SCROLL_BITS-1:0] model_scroll;
    logic [`RGB_BITS-1:0]    model_bg;

    int         tb_h;
    int         tb_v;
    video_out_t exp_d1;
    video_out_t exp_d2;
    logic       check_en;
    int         seed;
    string      test_name;
    int         scroll_values [3] = '{1, 5, 31};

    video_core i_video_core (
        .clk   (clk),
        .reset (reset),
        .host  (host),
        .video (video)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ======================================
    // Reference model
    // ======================================
    function automatic video_out_t expected_pixel(input int h, input int v);
        video_out_t             result;
        int                     map_x;
        logic [`INDEX_BITS-1:0] index;
        result    = '0;
        result.de = (h < `H_ACTIVE) && (v < `V_ACTIVE);
        result.hs = (h >= `HS_START) && (h < `HS_END);
        result.vs = (v >= `VS_START) && (v < `VS_END);
        if (result.de) begin
            // Scroll wraps at the map width in pixels
            map_x = (h + model_scroll) % (`MAP_COLS << `TILE_SHIFT);
            index = model_tiles[(v >> `TILE_SHIFT) * `MAP_COLS + (map_x >> `TILE_SHIFT)];
            result.rgb = (index == 0) ? model_bg : model_palette[index];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // ======================================
    // Compare process
    // ======================================
    always @(posedge clk) begin
        if (reset) begin
            tb_h   <= 0;
            tb_v   <= 0;
            exp_d1 <= '0;
            exp_d2 <= '0;
        end else begin
            check_value({test_name, " sync"}, {exp_d2.de, exp_d2.hs, exp_d2.vs},
                        {video.de, video.hs, video.vs});
            // Blanking rgb is always checked
            if (check_en || !exp_d2.de) begin
                check_value({test_name, " rgb"}, exp_d2.rgb, video.rgb);
            end
            exp_d2 <= exp_d1;
            exp_d1 <= expected_pixel(tb_h, tb_v);
            if (tb_h == `H_TOTAL - 1) begin
                tb_h <= 0;
                tb_v <= (tb_v == `V_TOTAL - 1) ? 0 : tb_v + 1;
            end else begin
                tb_h <= tb_h + 1;
            end
        end
    end

    // Bound checker failures
    always @(i_video_core.u_scanout.i_video_core_sva.failures) begin
        if (i_video_core.u_scanout.i_video_core_sva.failures != 0) begin
            $display("An assertion in the scanout checker failed");
            $display("ERRORS FOUND");
            $fatal(1, "Assertion failure");
        end
    end

    // Called 5 units after a rising edge
    task automatic write_host(input host_target_e target, input int addr,
                              input logic [`RGB_BITS-1:0] data);
        check_en    = 1'b0;
        host.wren   = 1'b1;
        host.target = target;
        host.addr   = addr[`ADDR_BITS-1:0];
        host.data   = data;
        @(posedge clk);
        #5;
        host.wren = 1'b0;
        case (target)
            HOST_TILE:    model_tiles[addr] = data[`INDEX_BITS-1:0];
            HOST_PALETTE: model_palette[addr] = data;
            HOST_SCROLL:  model_scroll = data[`SCROLL_BITS-1:0];
            default:      model_bg = data;
        endcase
    endtask

    task automatic wait_raster(input int line);
        int cycles;
        bit found;
        cycles = 0;
        found  = 1'b0;
        while (!found) begin
            @(posedge clk);
            #5;
            cycles++;
            found = (tb_h == 0) && (tb_v == line);
            if (!found && cycles > 2 * `H_TOTAL * `V_TOTAL) begin
                $display("Timeout while waiting for the start of line %0d", line);
                $display("ERRORS FOUND");
                $fatal(1, "Raster wait timed out");
            end
        end
    endtask

    // Lines 10 and 11 rebuild rows 0 and 1 with the new state
    task automatic settle_frame();
        wait_raster(10);
        wait_raster(0);
        check_en = 1'b1;
    endtask

    task automatic run_frames(input int count);
        repeat (count) begin
            wait_raster(0);
        end
    endtask

    // ======================================
    // Stimulus
    // ======================================
    initial begin
        seed         = 32'hec21;
        check_en     = 1'b0;
        test_name    = "reset_sync";
        reset        = 1'b1;
        host         = '0;
        model_scroll = '0;
        model_bg     = '0;
        for (int i = 0; i < `MAP_COLS*`MAP_ROWS; i++) begin
            model_tiles[i] = '0;
        end
        for (int i = 0; i < (1 << `INDEX_BITS); i++) begin
            model_palette[i] = '0;
        end
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;

        run_frames(2);

        test_name = "random_tiles";
        for (int i = 0; i < `MAP_COLS*`MAP_ROWS; i++) begin
            write_host(HOST_TILE, i, 24'($random(seed)) & 24'hf);
        end
        // Make sure the background colour shows up
        write_host(HOST_TILE, 2, 24'h0);
        write_host(HOST_TILE, 13, 24'h0);
        for (int i = 1; i < (1 << `INDEX_BITS); i++) begin
            write_host(HOST_PALETTE, i, 24'($random(seed)));
        end
        write_host(HOST_BGCOLOR, 0, 24'($random(seed)));
        write_host(HOST_SCROLL, 0, 24'h0);
        settle_frame();
        run_frames(1);

        for (int i = 0; i < 3; i++) begin
            test_name = $sformatf("scroll_%0d", scroll_values[i]);
            write_host(HOST_SCROLL, 0, 24'(scroll_values[i]));
            settle_frame();
            run_frames(1);
        end

        test_name = "bg_color";
        write_host(HOST_BGCOLOR, 0, 24'h00a5c3);
        settle_frame();
        run_frames(1);

        test_name = "palette_entry";
        write_host(HOST_PALETTE, (model_tiles[1] == 0) ? 1 : model_tiles[1], 24'h3c5a96);
        write_host(HOST_PALETTE, (model_tiles[9] == 0) ? 2 : model_tiles[9], 24'hf0e1d2);
        settle_frame();
        run_frames(1);

        test_name = "blanking";
        run_frames(2);

        $display("NO ERRORS");
        $finish;
    end

endmodule : video_core_tb

// ==== video_core.f ====
+incdir+rtl
rtl/video_pkg.sv
rtl/row_renderer.sv
rtl/row_buffer.sv
rtl/scanout.sv
rtl/video_core.sv
dv/video_core_sva.sv
dv/video_core_tb.sv
